// File: bench/trace_cases.txt
# S fire stall flush instr(hex) op arg(hex)   op 0 none 1 drain 2 status 3 clear 4 empty
# E tag instr fetch_cycle retire_cycle stalls (all hex, in retire order)
S 1 0 0 11110000 0 0
S 1 0 0 11110001 0 0
S 1 0 0 11110002 0 0
S 0 0 0 00000000 0 0
S 0 0 0 00000000 0 0
S 0 0 0 00000000 0 0
S 0 0 0 00000000 0 0
S 0 0 0 00000000 1 3
S 1 0 0 22220000 0 0
S 1 0 0 22220001 0 0
S 0 1 0 00000000 0 0
S 1 1 0 deadbeef 0 0
S 0 1 0 00000000 0 0
S 0 0 0 00000000 0 0
S 0 0 0 00000000 0 0
S 0 0 0 00000000 0 0
S 0 0 0 00000000 0 0
S 0 0 0 00000000 1 2
S 1 0 0 33330000 0 0
S 1 0 0 33330001 0 0
S 1 0 0 33330002 0 0
S 0 0 1 00000000 0 0
S 1 0 0 33330003 0 0
S 0 0 0 00000000 0 0
S 0 0 0 00000000 0 0
S 0 0 0 00000000 0 0
S 0 0 0 00000000 0 0
S 0 0 0 00000000 1 2
S 1 0 0 44440000 0 0
S 1 0 0 44440001 0 0
S 1 0 0 44440002 0 0
S 1 0 0 44440003 0 0
S 1 0 0 44440004 0 0
S 1 0 0 44440005 0 0
S 1 0 0 44440006 0 0
S 1 0 0 44440007 0 0
S 1 0 0 44440008 0 0
S 1 0 0 44440009 0 0
S 0 0 0 00000000 0 0
S 0 0 0 00000000 0 0
S 0 0 0 00000000 0 0
S 0 0 0 00000000 0 0
S 0 0 0 00000000 2 0208
S 0 0 0 00000000 3 0
S 0 0 0 00000000 2 0008
S 0 0 0 00000000 1 8
S 0 0 0 00000000 2 0000
S 0 0 0 00000000 4 0
S 0 0 0 00000000 0 0
S 0 0 0 00000000 0 0
S 0 0 0 00000000 0 0
S 0 0 0 00000000 0 0
E 00 11110000 0000 0005 00
E 01 11110001 0001 0006 00
E 02 11110002 0002 0007 00
E 03 22220000 0020 0028 03
E 04 22220001 0021 0029 03
E 05 33330000 003a 003f 00
E 08 33330003 003e 0043 00
E 09 44440000 0054 0059 00
E 0a 44440001 0055 005a 00
E 0b 44440002 0056 005b 00
E 0c 44440003 0057 005c 00
E 0d 44440004 0058 005d 00
E 0e 44440005 0059 005e 00
E 0f 44440006 005a 005f 00
E 10 44440007 005b 0060 00

// File: compile.f
design/trace_pkg.sv
design/stage_if.sv
design/stage_tracker.sv
design/tag_pipe.sv
design/stamp_pipe.sv
design/trace_buffer.sv
design/pipe_trace_top.sv
bench/trace_properties.sv
bench/trace_monitor.sv
bench/pipe_trace_tb.sv

// File: Makefile
TOP = pipe_trace_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module $(TOP) -Mdir obj_dir

run: build
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

lint:
	verilator --lint-only --timing -Wall -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: bench/pipe_trace_tb.sv
/*
 * testbench top for the pipeline trace unit
 * clock, reset, cases file stimulus, APB bursts, watchdog, closing line
 */
`timescale 1ns/10ps
`default_nettype none

module pipe_trace_tb;

    // one S row of the cases file
    typedef struct packed {
        logic        fire;
        logic        stall;
        logic        flush;
        logic [31:0] instr;
        logic [2:0]  op;
        logic [31:0] arg;
    } step_t;

    logic        clk;
    logic        rst;
    logic        fetch_fire;
    logic [31:0] instr;
    logic        stall;
    logic        flush;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    step_t steps [$];
    int    load_errors = 0;
    int    limit = 0;
    logic  started = 1'b0;
    int    total;

    always #5 clk = ~clk;

    pipe_trace_top dut (
        .clk(clk), .rst(rst), .fetch_fire(fetch_fire), .instr(instr),
        .stall(stall), .flush(flush), .paddr(paddr), .psel(psel),
        .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    trace_monitor mon (
        .clk(clk), .rst(rst), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    ////////////////////////////////////////
    // cases file
    ////////////////////////////////////////

    task automatic load_cases();
        int                    fd;
        int                    f_fire;
        int                    f_stall;
        int                    f_flush;
        int                    f_op;
        logic [31:0]           f_instr;
        logic [31:0]           f_arg;
        logic [31:0]           e_tag;
        logic [31:0]           e_instr;
        logic [31:0]           e_fc;
        logic [31:0]           e_rc;
        logic [31:0]           e_st;
        string                 line;
        step_t                 s;
        trace_pkg::trace_rec_t r;
        fd = $fopen("bench/trace_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open bench/trace_cases.txt");
            load_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if ($sscanf(line, "S %d %d %d %h %d %h", f_fire, f_stall, f_flush,
                        f_instr, f_op, f_arg) == 6) begin
                s.fire  = f_fire[0];
                s.stall = f_stall[0];
                s.flush = f_flush[0];
                s.instr = f_instr;
                s.op    = f_op[2:0];
                s.arg   = f_arg;
                steps.push_back(s);
            end else if ($sscanf(line, "E %h %h %h %h %h", e_tag, e_instr, e_fc,
                                 e_rc, e_st) == 5) begin
                r.tag          = e_tag[7:0];
                r.instr        = e_instr;
                r.fetch_cycle  = e_fc[15:0];
                r.retire_cycle = e_rc[15:0];
                r.stalls       = e_st[7:0];
                mon.add_record(r);
            end
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////
    // APB master, zero wait states
    ////////////////////////////////////////

    task automatic apb_xfer(input logic [7:0] addr, input logic wr, input logic [31:0] wdata);
        paddr   = addr;
        pwrite  = wr;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // status, instr, stamps, then info which pops
    task automatic drain(input int n);
        repeat (n) begin
            apb_xfer(trace_pkg::REG_STATUS, 1'b0, 32'd0);
            apb_xfer(trace_pkg::REG_INSTR, 1'b0, 32'd0);
            apb_xfer(trace_pkg::REG_STAMPS, 1'b0, 32'd0);
            apb_xfer(trace_pkg::REG_INFO, 1'b0, 32'd0);
        end
    endtask

    // one CPU cycle, then the row's APB work with the CPU idle
    task automatic run_step(input step_t s);
        fetch_fire = s.fire;
        stall      = s.stall;
        flush      = s.flush;
        instr      = s.instr;
        @(negedge clk);
        fetch_fire = 1'b0;
        stall      = 1'b0;
        flush      = 1'b0;
        instr      = '0;
        case (s.op)
            3'd1: drain(int'(s.arg));
            3'd2: begin
                mon.expect_status(s.arg);
                apb_xfer(trace_pkg::REG_STATUS, 1'b0, 32'd0);
            end
            3'd3: apb_xfer(trace_pkg::REG_STATUS, 1'b1, 32'hFFFF_FFFF);
            3'd4: begin
                apb_xfer(trace_pkg::REG_INSTR, 1'b0, 32'd0);
                apb_xfer(trace_pkg::REG_STAMPS, 1'b0, 32'd0);
                apb_xfer(trace_pkg::REG_INFO, 1'b0, 32'd0);
                apb_xfer(8'h14, 1'b0, 32'd0);
            end
            default: ;
        endcase
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        fetch_fire = 1'b0;
        instr      = '0;
        stall      = 1'b0;
        flush      = 1'b0;
        paddr      = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        pwdata     = '0;
        load_cases();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst     = 1'b0;
        limit   = 2 * steps.size() + 100;
        started = 1'b1;
        foreach (steps[i]) begin
            run_step(steps[i]);
        end
        repeat (4) @(negedge clk);
        mon.final_check();
        total = load_errors + mon.errors + dut.u_tracker.props.failures;
        $display("errors %0d, monitor %0d, assertions %0d, file %0d", total, mon.errors,
                 dut.u_tracker.props.failures, load_errors);
        if (total == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // watchdog, cycles counted from reset release
    initial begin
        wait (started);
        repeat (limit) @(posedge clk);
        $display("timeout, run did not finish within %0d cycles", limit);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/trace_monitor.sv
/*
 * APB read checker
 * expected record queue, armed status value, error count
 */
`timescale 1ns/10ps
`default_nettype none

module trace_monitor (
    input logic        clk,
    input logic        rst,
    input logic [7:0]  paddr,
    input logic        psel,
    input logic        penable,
    input logic        pwrite,
    input logic [31:0] prdata,
    input logic        pready,
    input logic        pslverr
);

    trace_pkg::trace_rec_t expq [$];
    logic [31:0]           exp_status = '0;
    logic                  status_armed = 1'b0;
    int                    errors = 0;

    // records in retire order, dropped ones never listed
    task automatic add_record(input trace_pkg::trace_rec_t r);
        expq.push_back(r);
    endtask

    // next status read must match this value
    task automatic expect_status(input logic [31:0] v);
        exp_status   = v;
        status_armed = 1'b1;
    endtask

    task automatic final_check();
        if (expq.size() != 0) begin
            $display("%0d expected records were never read back", expq.size());
            errors++;
        end
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic logic is_mapped(input logic [7:0] a);
        return a == 8'h00 || a == 8'h04 || a == 8'h08 || a == 8'h0C;
    endfunction

    ////////////////////////////////////////
    // read data against the head record
    ////////////////////////////////////////

    task automatic check_read();
        trace_pkg::trace_rec_t head;
        // an empty queue reads back as all zero
        head = (expq.size() == 0) ? '0 : expq[0];
        case (paddr)
            8'h00: begin
                if (status_armed) begin
                    compare("prdata REG_STATUS", prdata, exp_status);
                    status_armed = 1'b0;
                end
            end
            8'h04: compare("prdata REG_INSTR", prdata, head.instr);
            8'h08: compare("prdata REG_STAMPS", prdata, {head.retire_cycle, head.fetch_cycle});
            8'h0C: begin
                compare("prdata REG_INFO", prdata, {16'd0, head.stalls, head.tag});
                if (expq.size() != 0) begin
                    void'(expq.pop_front());
                end
            end
            default: compare("prdata unmapped", prdata, 32'd0);
        endcase
    endtask

    // sample at the access edge, inputs move on the falling edge
    always @(posedge clk) begin
        if (!rst) begin
            if (pready !== 1'b1) begin
                $display("pready went low at %0t", $time);
                errors++;
            end
            if (psel && penable) begin
                compare("pslverr", {31'd0, pslverr}, {31'd0, !is_mapped(paddr)});
                if (!pwrite) begin
                    check_read();
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/trace_properties.sv
/*
 * stage tracker assertions, bound into every stage_tracker
 * reset clear, flush and stall bubbles, hold against kill
 */
`timescale 1ns/10ps
`default_nettype none

module trace_properties (
    input logic                             clk,
    input logic                             rst,
    input logic                             stall,
    input logic                             flush,
    input logic [trace_pkg::NUM_STAGES-1:0] valid,
    input logic                             front_hold,
    input logic                             front_kill
);

    // read by the testbench top for the closing count
    int failures = 0;

    // every stage empty on the edge after a reset edge
    a_reset_clear: assert property (@(posedge clk) rst |=> (valid == '0))
        else begin failures++; $error("valid bits not cleared after reset"); end

    // flush empties fetch and decode
    a_flush_front: assert property (@(posedge clk) disable iff (rst)
        flush |=> (valid[trace_pkg::STG_D:trace_pkg::STG_F] == 2'b00))
        else begin failures++; $error("fetch or decode still valid after flush"); end

    // stall puts a bubble into execute
    a_stall_bubble: assert property (@(posedge clk) disable iff (rst)
        stall |=> !valid[trace_pkg::STG_X])
        else begin failures++; $error("execute still valid after stall"); end

    a_hold_kill: assert property (@(posedge clk) disable iff (rst)
        !(front_hold && front_kill))
        else begin failures++; $error("front hold and front kill both high"); end

endmodule

bind stage_tracker trace_properties props (
    .clk(clk), .rst(rst), .stall(stall), .flush(flush), .valid(valid_q),
    .front_hold(ctl.front_hold), .front_kill(ctl.front_kill)
);

`default_nettype wire

// File: design/pipe_trace_top.sv
/*
 * pipeline trace unit top level
 * stage tracker, tag pipe, stamp pipe and trace buffer on one stage bundle
 */
`timescale 1ns/10ps
`default_nettype none

module pipe_trace_top (
    input  logic                             clk,
    input  logic                             rst,
    // CPU observation
    input  logic                             fetch_fire,
    input  logic [trace_pkg::INSTR_W-1:0]    instr,
    input  logic                             stall,
    input  logic                             flush,
    // APB slave
    input  logic [trace_pkg::APB_ADDR_W-1:0] paddr,
    input  logic                             psel,
    input  logic                             penable,
    input  logic                             pwrite,
    input  logic [trace_pkg::APB_DATA_W-1:0] pwdata,
    output logic [trace_pkg::APB_DATA_W-1:0] prdata,
    output logic                             pready,
    output logic                             pslverr
);

    // write-back values from the two pipes
    logic [trace_pkg::CYCLE_W-1:0] cycle;
    logic [trace_pkg::TAG_W-1:0]   wb_tag;
    logic [trace_pkg::INSTR_W-1:0] wb_instr;
    logic [trace_pkg::CYCLE_W-1:0] wb_fetch_cycle;
    logic [trace_pkg::STALL_W-1:0] wb_stalls;

    stage_if ctl ();

    stage_tracker u_tracker (
        .clk(clk), .rst(rst), .fetch_fire(fetch_fire),
        .stall(stall), .flush(flush), .ctl(ctl.tracker)
    );

    tag_pipe u_tag_pipe (
        .clk(clk), .rst(rst), .instr(instr), .ctl(ctl.pipe),
        .wb_tag(wb_tag), .wb_instr(wb_instr)
    );

    stamp_pipe u_stamp_pipe (
        .clk(clk), .rst(rst), .ctl(ctl.pipe), .cycle(cycle),
        .wb_fetch_cycle(wb_fetch_cycle), .wb_stalls(wb_stalls)
    );

    trace_buffer u_trace_buffer (
        .clk(clk), .rst(rst), .ctl(ctl.pipe), .cycle(cycle),
        .wb_tag(wb_tag), .wb_instr(wb_instr),
        .wb_fetch_cycle(wb_fetch_cycle), .wb_stalls(wb_stalls),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

endmodule

`default_nettype wire

// File: design/trace_buffer.sv
/*
 * trace buffer
 * record assembly at retirement, eight-entry record queue,
 * saturating drop counter and the APB register file
 */
`timescale 1ns/10ps
`default_nettype none

module trace_buffer (
    input  logic                             clk,
    input  logic                             rst,
    stage_if.pipe                            ctl,
    input  logic [trace_pkg::CYCLE_W-1:0]    cycle,
    input  logic [trace_pkg::TAG_W-1:0]      wb_tag,
    input  logic [trace_pkg::INSTR_W-1:0]    wb_instr,
    input  logic [trace_pkg::CYCLE_W-1:0]    wb_fetch_cycle,
    input  logic [trace_pkg::STALL_W-1:0]    wb_stalls,
    input  logic [trace_pkg::APB_ADDR_W-1:0] paddr,
    input  logic                             psel,
    input  logic                             penable,
    input  logic                             pwrite,
    input  logic [trace_pkg::APB_DATA_W-1:0] pwdata,
    output logic [trace_pkg::APB_DATA_W-1:0] prdata,
    output logic                             pready,
    output logic                             pslverr
);

    trace_pkg::trace_rec_t           rec;
    trace_pkg::trace_rec_t           head;
    trace_pkg::trace_rec_t           queue [trace_pkg::TRACE_DEPTH];
    logic [trace_pkg::PTR_W-1:0]     wr_ptr;
    logic [trace_pkg::PTR_W-1:0]     rd_ptr;
    logic [trace_pkg::CNT_W-1:0]     count;
    logic [7:0]                      drop_cnt;
    logic                            empty;
    logic                            full;
    logic                            push;
    logic                            drop;
    logic                            pop;
    logic                            access;
    logic                            mapped;
    logic                            clr_drops;

    // record as it leaves write-back, stamped with this edge's cycle
    assign rec = '{tag: wb_tag, instr: wb_instr, fetch_cycle: wb_fetch_cycle,
                   retire_cycle: cycle, stalls: wb_stalls};

    assign empty = (count == '0);
    assign full  = (count == trace_pkg::CNT_W'(trace_pkg::TRACE_DEPTH));
    assign push  = ctl.retire && !full;
    assign drop  = ctl.retire && full;

    ////////////////////////////////////////
    // APB decode
    ////////////////////////////////////////

    assign access = psel && penable;
    assign mapped = (paddr == trace_pkg::REG_STATUS) || (paddr == trace_pkg::REG_INSTR) ||
                    (paddr == trace_pkg::REG_STAMPS) || (paddr == trace_pkg::REG_INFO);
    // info read consumes the head record
    assign pop       = access && !pwrite && (paddr == trace_pkg::REG_INFO) && !empty;
    // write data is ignored, any write clears
    assign clr_drops = access && pwrite && (paddr == trace_pkg::REG_STATUS);

    ////////////////////////////////////////
    // record queue
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (push) begin
            queue[wr_ptr] <= rec;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // drops saturate at 255; a drop on the clearing edge still counts
    always_ff @(posedge clk) begin
        if (rst) begin
            drop_cnt <= '0;
        end else if (clr_drops) begin
            drop_cnt <= {7'd0, drop};
        end else if (drop && !(&drop_cnt)) begin
            drop_cnt <= drop_cnt + 1'b1;
        end
    end

    assign head = queue[rd_ptr];

    ////////////////////////////////////////
    // read data, zero wait states
    ////////////////////////////////////////

    always_comb begin
        prdata = '0;
        case (paddr)
            trace_pkg::REG_STATUS: prdata = {16'd0, drop_cnt, 4'd0, count};
            trace_pkg::REG_INSTR:  prdata = empty ? '0 : head.instr;
            trace_pkg::REG_STAMPS: prdata = empty ? '0 : {head.retire_cycle, head.fetch_cycle};
            trace_pkg::REG_INFO:   prdata = empty ? '0 : {16'd0, head.stalls, head.tag};
            default:               prdata = '0;
        endcase
    end

    assign pready  = 1'b1;
    assign pslverr = access && !mapped;

endmodule

`default_nettype wire

// File: design/stamp_pipe.sv
/*
 * stamp pipe
 * free cycle counter, fetch stamps and saturating stall counts
 * carried through the stages
 */
`timescale 1ns/10ps
`default_nettype none

module stamp_pipe (
    input  logic                          clk,
    input  logic                          rst,
    stage_if.pipe                         ctl,
    output logic [trace_pkg::CYCLE_W-1:0] cycle,
    output logic [trace_pkg::CYCLE_W-1:0] wb_fetch_cycle,
    output logic [trace_pkg::STALL_W-1:0] wb_stalls
);

    logic [trace_pkg::CYCLE_W-1:0] cycle_q;
    logic [trace_pkg::CYCLE_W-1:0] fc_q [trace_pkg::NUM_STAGES];
    logic [trace_pkg::STALL_W-1:0] st_q [trace_pkg::NUM_STAGES];
    logic                          front_go;

    // stall count sticks at all ones
    function automatic logic [trace_pkg::STALL_W-1:0] sat_inc(
        input logic [trace_pkg::STALL_W-1:0] v
    );
        if (&v) begin
            return v;
        end
        return v + 1'b1;
    endfunction

    assign front_go = !ctl.front_hold && !ctl.front_kill;

    // counts every edge after reset, wraps
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_q <= '0;
        end else begin
            cycle_q <= cycle_q + 1'b1;
        end
    end

    ////////////////////////////////////////
    // front end, stamp on load, count holds
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (ctl.fetch_load) begin
            fc_q[trace_pkg::STG_F] <= cycle_q;
            st_q[trace_pkg::STG_F] <= '0;
        end else if (ctl.front_hold && ctl.valid[trace_pkg::STG_F]) begin
            st_q[trace_pkg::STG_F] <= sat_inc(st_q[trace_pkg::STG_F]);
        end
        if (ctl.front_hold && ctl.valid[trace_pkg::STG_D]) begin
            st_q[trace_pkg::STG_D] <= sat_inc(st_q[trace_pkg::STG_D]);
        end else if (front_go && ctl.valid[trace_pkg::STG_F]) begin
            fc_q[trace_pkg::STG_D] <= fc_q[trace_pkg::STG_F];
            st_q[trace_pkg::STG_D] <= st_q[trace_pkg::STG_F];
        end
    end

    ////////////////////////////////////////
    // back end, plain shift
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (front_go && ctl.valid[trace_pkg::STG_D]) begin
            fc_q[trace_pkg::STG_X] <= fc_q[trace_pkg::STG_D];
            st_q[trace_pkg::STG_X] <= st_q[trace_pkg::STG_D];
        end
        if (ctl.valid[trace_pkg::STG_X]) begin
            fc_q[trace_pkg::STG_M] <= fc_q[trace_pkg::STG_X];
            st_q[trace_pkg::STG_M] <= st_q[trace_pkg::STG_X];
        end
        if (ctl.valid[trace_pkg::STG_M]) begin
            fc_q[trace_pkg::STG_W] <= fc_q[trace_pkg::STG_M];
            st_q[trace_pkg::STG_W] <= st_q[trace_pkg::STG_M];
        end
    end

    assign cycle          = cycle_q;
    assign wb_fetch_cycle = fc_q[trace_pkg::STG_W];
    assign wb_stalls      = st_q[trace_pkg::STG_W];

endmodule

`default_nettype wire

// File: design/tag_pipe.sv
/*
 * tag pipe
 * sequence tag counter, tag and instruction word carried through the stages
 */
`timescale 1ns/10ps
`default_nettype none

module tag_pipe (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [trace_pkg::INSTR_W-1:0] instr,
    stage_if.pipe                         ctl,
    output logic [trace_pkg::TAG_W-1:0]   wb_tag,
    output logic [trace_pkg::INSTR_W-1:0] wb_instr
);

    logic [trace_pkg::TAG_W-1:0]   next_tag;
    logic [trace_pkg::TAG_W-1:0]   tag_q   [trace_pkg::NUM_STAGES];
    logic [trace_pkg::INSTR_W-1:0] instr_q [trace_pkg::NUM_STAGES];
    logic                          front_go;

    // decode to execute moves only on a plain advance
    assign front_go = !ctl.front_hold && !ctl.front_kill;

    // tag counter, flushed fetches still consume a tag
    always_ff @(posedge clk) begin
        if (rst) begin
            next_tag <= '0;
        end else if (ctl.fetch_load) begin
            next_tag <= next_tag + 1'b1;
        end
    end

    // stage registers, only live instructions are captured
    always_ff @(posedge clk) begin
        if (ctl.fetch_load) begin
            tag_q[trace_pkg::STG_F]   <= next_tag;
            instr_q[trace_pkg::STG_F] <= instr;
        end
        if (front_go && ctl.valid[trace_pkg::STG_F]) begin
            tag_q[trace_pkg::STG_D]   <= tag_q[trace_pkg::STG_F];
            instr_q[trace_pkg::STG_D] <= instr_q[trace_pkg::STG_F];
        end
        if (front_go && ctl.valid[trace_pkg::STG_D]) begin
            tag_q[trace_pkg::STG_X]   <= tag_q[trace_pkg::STG_D];
            instr_q[trace_pkg::STG_X] <= instr_q[trace_pkg::STG_D];
        end
        // memory and write-back always advance
        if (ctl.valid[trace_pkg::STG_X]) begin
            tag_q[trace_pkg::STG_M]   <= tag_q[trace_pkg::STG_X];
            instr_q[trace_pkg::STG_M] <= instr_q[trace_pkg::STG_X];
        end
        if (ctl.valid[trace_pkg::STG_M]) begin
            tag_q[trace_pkg::STG_W]   <= tag_q[trace_pkg::STG_M];
            instr_q[trace_pkg::STG_W] <= instr_q[trace_pkg::STG_M];
        end
    end

    assign wb_tag   = tag_q[trace_pkg::STG_W];
    assign wb_instr = instr_q[trace_pkg::STG_W];

endmodule

`default_nettype wire

// File: design/stage_tracker.sv
/*
 * stage tracker
 * per-stage valid bits and the flush, stall and advance decisions
 * that both pipes follow
 */
`timescale 1ns/10ps
`default_nettype none

module stage_tracker (
    input  logic clk,
    input  logic rst,
    input  logic fetch_fire,
    input  logic stall,
    input  logic flush,
    stage_if.tracker ctl
);

    logic [trace_pkg::NUM_STAGES-1:0] valid_q;
    logic                             load;

    // fire only counts on a plain advance
    assign load = fetch_fire && !stall && !flush;

    ////////////////////////////////////////
    // valid bits
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else begin
            // back end never waits
            valid_q[trace_pkg::STG_M] <= valid_q[trace_pkg::STG_X];
            valid_q[trace_pkg::STG_W] <= valid_q[trace_pkg::STG_M];
            if (flush) begin
                // front end emptied, bubble into execute
                valid_q[trace_pkg::STG_F] <= 1'b0;
                valid_q[trace_pkg::STG_D] <= 1'b0;
                valid_q[trace_pkg::STG_X] <= 1'b0;
            end else if (stall) begin
                // front end keeps its bits, bubble into execute
                valid_q[trace_pkg::STG_X] <= 1'b0;
            end else begin
                valid_q[trace_pkg::STG_F] <= load;
                valid_q[trace_pkg::STG_D] <= valid_q[trace_pkg::STG_F];
                valid_q[trace_pkg::STG_X] <= valid_q[trace_pkg::STG_D];
            end
        end
    end

    ////////////////////////////////////////
    // controls for the pipes
    ////////////////////////////////////////

    assign ctl.fetch_load = load;
    // flush outranks stall, so hold and kill never overlap
    assign ctl.front_hold = stall && !flush;
    assign ctl.front_kill = flush;
    assign ctl.valid      = valid_q;
    assign ctl.retire     = valid_q[trace_pkg::STG_W];

endmodule

`default_nettype wire

// File: design/stage_if.sv
/*
 * stage control bundle
 * driven by the stage tracker, followed by the tag and stamp pipes
 */
`timescale 1ns/10ps
`default_nettype none

interface stage_if;

    // new instruction enters fetch at this edge
    logic                             fetch_load;
    // fetch and decode keep their contents
    logic                             front_hold;
    // fetch and decode are emptied
    logic                             front_kill;
    // one bit per stage, fetch at bit 0
    logic [trace_pkg::NUM_STAGES-1:0] valid;
    // write-back holds a live instruction
    logic                             retire;

    modport tracker (
        output fetch_load, front_hold, front_kill, valid, retire
    );

    modport pipe (
        input fetch_load, front_hold, front_kill, valid, retire
    );

endinterface

`default_nettype wire

// File: design/trace_pkg.sv
/*
 * shared definitions for the pipeline trace unit
 * stage indices, field widths, queue depth
 * packed trace record and APB register map
 */
`default_nettype none

package trace_pkg;

    // pipeline shape
    localparam int NUM_STAGES = 5;
    localparam int STG_F      = 0;
    localparam int STG_D      = 1;
    localparam int STG_X      = 2;
    localparam int STG_M      = 3;
    localparam int STG_W      = 4;

    // field widths, tag and cycle wrap, stalls saturate
    localparam int TAG_W   = 8;
    localparam int INSTR_W = 32;
    localparam int CYCLE_W = 16;
    localparam int STALL_W = 8;

    // record queue
    localparam int TRACE_DEPTH = 8;
    localparam int PTR_W       = $clog2(TRACE_DEPTH);
    localparam int CNT_W       = PTR_W + 1;

    // APB register map
    localparam int APB_ADDR_W = 8;
    localparam int APB_DATA_W = 32;
    localparam logic [APB_ADDR_W-1:0] REG_STATUS = 8'h00;
    localparam logic [APB_ADDR_W-1:0] REG_INSTR  = 8'h04;
    localparam logic [APB_ADDR_W-1:0] REG_STAMPS = 8'h08;
    localparam logic [APB_ADDR_W-1:0] REG_INFO   = 8'h0C;

    // one retired instruction, 80 bits
    typedef struct packed {
        logic [TAG_W-1:0]   tag;
        logic [INSTR_W-1:0] instr;
        logic [CYCLE_W-1:0] fetch_cycle;
        logic [CYCLE_W-1:0] retire_cycle;
        logic [STALL_W-1:0] stalls;
    } trace_rec_t;

endpackage

`default_nettype wire
